// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_core_slice -f project.f \
		--Mdir obj_dir -o tb_core_slice
	obj_dir/tb_core_slice > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
	cat sim.log
	! grep -q "TEST FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: include/core_macros.svh
/*
 * Core width parameters.
 * Data path width and register file depth for the RV32I slice.
 */

`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data, address and immediate width.
`define XLEN 32

// Number of architectural integer registers.
`define REG_NUM 32

`endif

// File: project.f
+incdir+include
src/core_pkg.sv
src/idu_ex_if.sv
src/reg_file.sv
src/idu_decode.sv
src/idu_reg.sv
src/exu_alu.sv
src/core_slice_top.sv
test/tb_core_slice.sv

// File: src/core_pkg.sv
/*
 * Core package.
 * Vector types for words, register indices and instructions, and the
 * select encodings passed from decode to execute.
 */

`include "core_macros.svh"

package core_pkg;

    typedef logic [`XLEN-1:0]              word_t;
    typedef logic [$clog2(`REG_NUM)-1:0]   reg_addr_t;
    typedef logic [31:0]                   instr_t;

    // ALU function code, same encoding as funct3.
    typedef logic [2:0] alu_op_t;

    // Memory width and sign, same encoding as funct3.
    typedef logic [2:0] mem_sel_t;

    typedef enum logic [1:0] {
        A_RS1  = 2'd0,
        A_PC   = 2'd1,
        A_ZERO = 2'd2
    } alu_a_sel_t;

    typedef enum logic [1:0] {
        B_RS2  = 2'd0,
        B_IMM  = 2'd1,
        B_FOUR = 2'd2
    } alu_b_sel_t;

    typedef enum logic [2:0] {
        COMP_NONE = 3'd0,
        COMP_EQ   = 3'd1,
        COMP_NE   = 3'd2,
        COMP_LT   = 3'd3,
        COMP_GE   = 3'd4,
        COMP_LTU  = 3'd5,
        COMP_GEU  = 3'd6
    } comp_sel_t;

    localparam alu_op_t ALU_ADD  = 3'b000;
    localparam alu_op_t ALU_SLL  = 3'b001;
    localparam alu_op_t ALU_SLT  = 3'b010;
    localparam alu_op_t ALU_SLTU = 3'b011;
    localparam alu_op_t ALU_XOR  = 3'b100;
    localparam alu_op_t ALU_SR   = 3'b101;
    localparam alu_op_t ALU_OR   = 3'b110;
    localparam alu_op_t ALU_AND  = 3'b111;

endpackage

// File: src/core_slice_top.sv
/*
 * Decode-to-execute slice of an RV32I core.
 * Connects the decoder, pipeline register, execute stage and register file.
 */

`timescale 1ns/100ps

module core_slice_top (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               instr_valid_i,
    input  core_pkg::instr_t   instr_i,
    input  core_pkg::word_t    pc_i,
    output logic               result_valid_o,
    output core_pkg::word_t    result_o,
    output logic               pc_wr_en_o,
    output core_pkg::word_t    pc_target_o,
    output logic               dram_wr_en_o,
    output logic               dram_rd_en_o,
    output core_pkg::mem_sel_t dram_wr_sel_o,
    output core_pkg::mem_sel_t dram_rd_sel_o,
    output core_pkg::word_t    dram_addr_o,
    output core_pkg::word_t    dram_wr_data_o
);
    import core_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      rf_wr_en;
    reg_addr_t rf_wr_addr;
    word_t     rf_wr_data;

    idu_ex_if id_if ();
    idu_ex_if ex_if ();

    idu_decode u_idu_decode (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .id_o          (id_if.decode)
    );

    idu_reg u_idu_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .id_i    (id_if.execute),
        .ex_o    (ex_if.decode)
    );

    exu_alu u_exu_alu (
        .ex_i           (ex_if.execute),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .pc_wr_en_o     (pc_wr_en_o),
        .pc_target_o    (pc_target_o),
        .dram_wr_en_o   (dram_wr_en_o),
        .dram_rd_en_o   (dram_rd_en_o),
        .dram_wr_sel_o  (dram_wr_sel_o),
        .dram_rd_sel_o  (dram_rd_sel_o),
        .dram_addr_o    (dram_addr_o),
        .dram_wr_data_o (dram_wr_data_o),
        .rf_wr_en_o     (rf_wr_en),
        .rf_wr_addr_o   (rf_wr_addr),
        .rf_wr_data_o   (rf_wr_data)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_en_i    (rf_wr_en),
        .wr_addr_i  (rf_wr_addr),
        .wr_data_i  (rf_wr_data)
    );

endmodule

// File: src/exu_alu.sv
/*
 * Execute stage.
 * Operand selection, ALU, branch comparator, jump and branch target,
 * data memory control and register writeback.
 */

`timescale 1ns/100ps

module exu_alu (
    idu_ex_if.execute           ex_i,
    output logic                result_valid_o,
    output core_pkg::word_t     result_o,
    output logic                pc_wr_en_o,
    output core_pkg::word_t     pc_target_o,
    output logic                dram_wr_en_o,
    output logic                dram_rd_en_o,
    output core_pkg::mem_sel_t  dram_wr_sel_o,
    output core_pkg::mem_sel_t  dram_rd_sel_o,
    output core_pkg::word_t     dram_addr_o,
    output core_pkg::word_t     dram_wr_data_o,
    output logic                rf_wr_en_o,
    output core_pkg::reg_addr_t rf_wr_addr_o,
    output core_pkg::word_t     rf_wr_data_o
);
    import core_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t sum;
    word_t alu_result;
    word_t rs1_target;
    logic  cmp_pass;

    always_comb begin
        case (ex_i.alu_a_sel)
            A_RS1:   op_a = ex_i.rs1_rd_data;
            A_PC:    op_a = ex_i.pc;
            default: op_a = '0;
        endcase
        case (ex_i.alu_b_sel)
            B_RS2:   op_b = ex_i.rs2_rd_data;
            B_IMM:   op_b = ex_i.imm_rd_data;
            B_FOUR:  op_b = 4;
            default: op_b = '0;
        endcase
    end

    assign sum = op_a + op_b;

    always_comb begin
        case (ex_i.alu_op_1_sel)
            ALU_ADD:  alu_result = ex_i.alu_op_0_sel ? (op_a - op_b) : sum;
            ALU_SLL:  alu_result = op_a << op_b[4:0];
            ALU_SLT:  alu_result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_result = word_t'(op_a < op_b);
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SR:   alu_result = ex_i.alu_op_0_sel ? word_t'($signed(op_a) >>> op_b[4:0])
                                                     : (op_a >> op_b[4:0]);
            ALU_OR:   alu_result = op_a | op_b;
            default:  alu_result = op_a & op_b;
        endcase
    end

    // Non-branch PC writes are unconditional.
    always_comb begin
        case (ex_i.alu_comp_sel)
            COMP_EQ:  cmp_pass = (op_a == op_b);
            COMP_NE:  cmp_pass = (op_a != op_b);
            COMP_LT:  cmp_pass = ($signed(op_a) < $signed(op_b));
            COMP_GE:  cmp_pass = ($signed(op_a) >= $signed(op_b));
            COMP_LTU: cmp_pass = (op_a < op_b);
            COMP_GEU: cmp_pass = (op_a >= op_b);
            default:  cmp_pass = 1'b1;
        endcase
    end

    assign rs1_target  = ex_i.rs1_rd_data + ex_i.imm_rd_data;
    assign pc_target_o = ex_i.pc_wr_sel ? {rs1_target[$bits(word_t)-1:1], 1'b0}
                                        : (ex_i.pc + ex_i.imm_rd_data);
    assign pc_wr_en_o  = ex_i.pc_wr_en & cmp_pass;

    assign result_valid_o = ex_i.valid;
    assign result_o       = alu_result;

    assign dram_wr_en_o   = ex_i.dram_wr_en;
    assign dram_rd_en_o   = ex_i.dram_rd_en;
    assign dram_wr_sel_o  = ex_i.dram_wr_sel;
    assign dram_rd_sel_o  = ex_i.dram_rd_sel;
    assign dram_addr_o    = sum;
    assign dram_wr_data_o = ex_i.rs2_rd_data;

    assign rf_wr_en_o   = ex_i.valid & ex_i.rd_wr_en;
    assign rf_wr_addr_o = ex_i.rd_addr;
    assign rf_wr_data_o = alu_result;

endmodule

// File: src/idu_decode.sv
/*
 * RV32I instruction decoder.
 * Splits the instruction word, builds the immediate and maps the opcode
 * to the PC, ALU, comparator and data memory selects.
 */

`timescale 1ns/100ps

module idu_decode (
    input  logic                instr_valid_i,
    input  core_pkg::instr_t    instr_i,
    input  core_pkg::word_t     pc_i,
    output core_pkg::reg_addr_t rs1_addr_o,
    output core_pkg::reg_addr_t rs2_addr_o,
    input  core_pkg::word_t     rs1_data_i,
    input  core_pkg::word_t     rs2_data_i,
    idu_ex_if.decode            id_o
);
    import core_pkg::*;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [6:0] opcode;
    logic [2:0] funct3;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    word_t      imm;
    alu_a_sel_t a_sel;
    alu_b_sel_t b_sel;
    comp_sel_t  comp_sel;
    logic       op_0_sel;
    alu_op_t    op_1_sel;
    logic       pc_sel;
    logic       pc_en;
    logic       rd_en;
    logic       mem_rd;
    logic       mem_wr;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        imm      = '0;
        a_sel    = A_RS1;
        b_sel    = B_RS2;
        comp_sel = COMP_NONE;
        op_0_sel = 1'b0;
        op_1_sel = ALU_ADD;
        pc_sel   = 1'b0;
        pc_en    = 1'b0;
        rd_en    = 1'b0;
        mem_rd   = 1'b0;
        mem_wr   = 1'b0;
        case (opcode)
            OPC_OP: begin
                op_1_sel = funct3;
                op_0_sel = instr_i[30];
                rd_en    = 1'b1;
            end
            OPC_OP_IMM: begin
                b_sel    = B_IMM;
                imm      = imm_i;
                op_1_sel = funct3;
                // Only SRAI uses bit 30, for ADDI it is immediate data.
                op_0_sel = (funct3 == ALU_SR) ? instr_i[30] : 1'b0;
                rd_en    = 1'b1;
            end
            OPC_LUI: begin
                a_sel = A_ZERO;
                b_sel = B_IMM;
                imm   = imm_u;
                rd_en = 1'b1;
            end
            OPC_AUIPC: begin
                a_sel = A_PC;
                b_sel = B_IMM;
                imm   = imm_u;
                rd_en = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                a_sel  = A_PC;
                b_sel  = B_FOUR;
                imm    = (opcode == OPC_JAL) ? imm_j : imm_i;
                pc_sel = (opcode == OPC_JALR);
                pc_en  = 1'b1;
                rd_en  = 1'b1;
            end
            OPC_BRANCH: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  comp_sel = COMP_EQ;
                    3'b001:  comp_sel = COMP_NE;
                    3'b100:  comp_sel = COMP_LT;
                    3'b101:  comp_sel = COMP_GE;
                    3'b110:  comp_sel = COMP_LTU;
                    3'b111:  comp_sel = COMP_GEU;
                    default: comp_sel = COMP_NONE;
                endcase
                pc_en = (comp_sel != COMP_NONE);
            end
            OPC_LOAD: begin
                b_sel  = B_IMM;
                imm    = imm_i;
                mem_rd = 1'b1;
            end
            OPC_STORE: begin
                b_sel  = B_IMM;
                imm    = imm_s;
                mem_wr = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    assign id_o.valid        = instr_valid_i;
    assign id_o.pc_wr_en     = pc_en & instr_valid_i;
    assign id_o.pc_wr_sel    = pc_sel;
    assign id_o.alu_a_sel    = a_sel;
    assign id_o.alu_b_sel    = b_sel;
    assign id_o.alu_comp_sel = comp_sel;
    assign id_o.alu_op_0_sel = op_0_sel;
    assign id_o.alu_op_1_sel = op_1_sel;
    assign id_o.dram_wr_en   = mem_wr & instr_valid_i;
    assign id_o.dram_rd_en   = mem_rd & instr_valid_i;
    assign id_o.dram_wr_sel  = funct3;
    assign id_o.dram_rd_sel  = funct3;
    assign id_o.rd_wr_en     = rd_en & instr_valid_i;
    assign id_o.rd_addr      = instr_i[11:7];
    assign id_o.pc           = pc_i;
    assign id_o.rs1_rd_data  = rs1_data_i;
    assign id_o.rs2_rd_data  = rs2_data_i;
    assign id_o.imm_rd_data  = imm;

endmodule

// File: src/idu_ex_if.sv
/*
 * Decode to execute bundle.
 * Carries control selects and operand data for one instruction.
 */

`timescale 1ns/100ps

interface idu_ex_if;
    import core_pkg::*;

    logic       valid;
    logic       pc_wr_en;
    logic       pc_wr_sel;
    alu_a_sel_t alu_a_sel;
    alu_b_sel_t alu_b_sel;
    comp_sel_t  alu_comp_sel;
    logic       alu_op_0_sel;
    alu_op_t    alu_op_1_sel;
    logic       dram_wr_en;
    logic       dram_rd_en;
    mem_sel_t   dram_wr_sel;
    mem_sel_t   dram_rd_sel;
    logic       rd_wr_en;
    reg_addr_t  rd_addr;
    word_t      pc;
    word_t      rs1_rd_data;
    word_t      rs2_rd_data;
    word_t      imm_rd_data;

    modport decode (
        output valid, pc_wr_en, pc_wr_sel, alu_a_sel, alu_b_sel, alu_comp_sel,
               alu_op_0_sel, alu_op_1_sel, dram_wr_en, dram_rd_en, dram_wr_sel,
               dram_rd_sel, rd_wr_en, rd_addr, pc, rs1_rd_data, rs2_rd_data,
               imm_rd_data
    );

    modport execute (
        input valid, pc_wr_en, pc_wr_sel, alu_a_sel, alu_b_sel, alu_comp_sel,
              alu_op_0_sel, alu_op_1_sel, dram_wr_en, dram_rd_en, dram_wr_sel,
              dram_rd_sel, rd_wr_en, rd_addr, pc, rs1_rd_data, rs2_rd_data,
              imm_rd_data
    );

endinterface

// File: src/idu_reg.sv
/*
 * Decode/execute pipeline register.
 * Holds the decoded bundle for one cycle.
 */

`timescale 1ns/100ps

module idu_reg (
    input  logic       clk_i,
    input  logic       rst_n_i,
    idu_ex_if.execute  id_i,
    idu_ex_if.decode   ex_o
);
    import core_pkg::*;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_o.valid        <= 1'b0;
            ex_o.pc_wr_en     <= 1'b0;
            ex_o.pc_wr_sel    <= 1'b0;
            ex_o.alu_a_sel    <= A_RS1;
            ex_o.alu_b_sel    <= B_RS2;
            ex_o.alu_comp_sel <= COMP_NONE;
            ex_o.alu_op_0_sel <= 1'b0;
            ex_o.alu_op_1_sel <= ALU_ADD;
            ex_o.dram_wr_en   <= 1'b0;
            ex_o.dram_rd_en   <= 1'b0;
            ex_o.dram_wr_sel  <= '0;
            ex_o.dram_rd_sel  <= '0;
            ex_o.rd_wr_en     <= 1'b0;
            ex_o.rd_addr      <= '0;
            ex_o.pc           <= '0;
            ex_o.rs1_rd_data  <= '0;
            ex_o.rs2_rd_data  <= '0;
            ex_o.imm_rd_data  <= '0;
        end else begin
            ex_o.valid        <= id_i.valid;
            ex_o.pc_wr_en     <= id_i.pc_wr_en;
            ex_o.pc_wr_sel    <= id_i.pc_wr_sel;
            ex_o.alu_a_sel    <= id_i.alu_a_sel;
            ex_o.alu_b_sel    <= id_i.alu_b_sel;
            ex_o.alu_comp_sel <= id_i.alu_comp_sel;
            ex_o.alu_op_0_sel <= id_i.alu_op_0_sel;
            ex_o.alu_op_1_sel <= id_i.alu_op_1_sel;
            ex_o.dram_wr_en   <= id_i.dram_wr_en;
            ex_o.dram_rd_en   <= id_i.dram_rd_en;
            ex_o.dram_wr_sel  <= id_i.dram_wr_sel;
            ex_o.dram_rd_sel  <= id_i.dram_rd_sel;
            ex_o.rd_wr_en     <= id_i.rd_wr_en;
            ex_o.rd_addr      <= id_i.rd_addr;
            ex_o.pc           <= id_i.pc;
            ex_o.rs1_rd_data  <= id_i.rs1_rd_data;
            ex_o.rs2_rd_data  <= id_i.rs2_rd_data;
            ex_o.imm_rd_data  <= id_i.imm_rd_data;
        end
    end

    // Decode must qualify the PC write with valid.
    a_pc_wr_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ex_o.pc_wr_en |-> ex_o.valid);

    // An instruction is either a load or a store, never both.
    a_dram_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(ex_o.dram_wr_en && ex_o.dram_rd_en));

endmodule

// File: src/reg_file.sv
/*
 * Integer register file.
 * Two combinational read ports and one write port with write-to-read
 * bypass. Register x0 is hardwired to zero.
 */

`timescale 1ns/100ps
`include "core_macros.svh"

module reg_file (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  core_pkg::reg_addr_t rs1_addr_i,
    input  core_pkg::reg_addr_t rs2_addr_i,
    output core_pkg::word_t    rs1_data_o,
    output core_pkg::word_t    rs2_data_o,
    input  logic               wr_en_i,
    input  core_pkg::reg_addr_t wr_addr_i,
    input  core_pkg::word_t    wr_data_i
);
    import core_pkg::*;

    word_t regs [1:`REG_NUM-1];

    function automatic word_t read_port(reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_en_i && (wr_addr_i == addr)) begin
            data = wr_data_i;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    // x0 stays zero on both ports, also while it is the write target.
    a_x0_rs1_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rs1_addr_i == '0) |-> (rs1_data_o == '0));

    a_x0_rs2_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rs2_addr_i == '0) |-> (rs2_data_o == '0));

endmodule

// File: test/tb_core_slice.sv
/*
 * Testbench for the RV32I decode-to-execute slice.
 * Applies a table of instructions back to back and checks result, branch,
 * target and data memory outputs one cycle later.
 */

`timescale 1ns/100ps

module tb_core_slice;
    import core_pkg::*;

    localparam int NUM      = 25;
    localparam int MAX_WAIT = 10;

    localparam int OPC_OP_IMM = 'h13;
    localparam int OPC_LUI    = 'h37;
    localparam int OPC_AUIPC  = 'h17;
    localparam int OPC_JALR   = 'h67;
    localparam int OPC_LOAD   = 'h03;

    logic     clk_i;
    logic     rst_n_i;
    logic     instr_valid_i;
    instr_t   instr_i;
    word_t    pc_i;
    logic     result_valid_o;
    word_t    result_o;
    logic     pc_wr_en_o;
    word_t    pc_target_o;
    logic     dram_wr_en_o;
    logic     dram_rd_en_o;
    mem_sel_t dram_wr_sel_o;
    mem_sel_t dram_rd_sel_o;
    word_t    dram_addr_o;
    word_t    dram_wr_data_o;

    // Stimulus and expected values, one column per array.
    string    t_name [NUM];
    instr_t   t_instr [NUM];
    word_t    t_pc [NUM];
    logic     t_chk_res [NUM];
    word_t    t_res [NUM];
    logic     t_br [NUM];
    word_t    t_tgt [NUM];
    logic     t_rd [NUM];
    logic     t_wr [NUM];
    mem_sel_t t_msel [NUM];
    word_t    t_addr [NUM];
    word_t    t_wdata [NUM];

    int   entry_count = 0;
    int   error_count = 0;
    int   pass_count  = 0;
    int   fail_count  = 0;
    logic timed_out   = 1'b0;

    core_slice_top u_core_slice_top (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .pc_i           (pc_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .pc_wr_en_o     (pc_wr_en_o),
        .pc_target_o    (pc_target_o),
        .dram_wr_en_o   (dram_wr_en_o),
        .dram_rd_en_o   (dram_rd_en_o),
        .dram_wr_sel_o  (dram_wr_sel_o),
        .dram_rd_sel_o  (dram_rd_sel_o),
        .dram_addr_o    (dram_addr_o),
        .dram_wr_data_o (dram_wr_data_o)
    );

    always #4 clk_i = ~clk_i;

    function automatic instr_t r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic instr_t i_type(int imm, int rs1, int f3, int rd, int opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic instr_t s_type(int imm, int rs2, int rs1, int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic instr_t b_type(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic instr_t u_type(int imm, int rd, int opc);
        return {imm[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic instr_t j_type(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // Instructions sit at consecutive word addresses from 0x100.
    task automatic start_entry(string name, instr_t instr);
        t_name[entry_count]    = name;
        t_instr[entry_count]   = instr;
        t_pc[entry_count]      = word_t'(32'h100 + 4 * entry_count);
        t_chk_res[entry_count] = 1'b0;
        t_res[entry_count]     = '0;
        t_br[entry_count]      = 1'b0;
        t_tgt[entry_count]     = '0;
        t_rd[entry_count]      = 1'b0;
        t_wr[entry_count]      = 1'b0;
        t_msel[entry_count]    = '0;
        t_addr[entry_count]    = '0;
        t_wdata[entry_count]   = '0;
    endtask

    task automatic alu_entry(string name, instr_t instr, word_t res);
        start_entry(name, instr);
        t_chk_res[entry_count] = 1'b1;
        t_res[entry_count]     = res;
        entry_count++;
    endtask

    task automatic ctrl_entry(string name, instr_t instr, logic chk_res, word_t res,
                              logic taken, word_t tgt);
        start_entry(name, instr);
        t_chk_res[entry_count] = chk_res;
        t_res[entry_count]     = res;
        t_br[entry_count]      = taken;
        t_tgt[entry_count]     = tgt;
        entry_count++;
    endtask

    task automatic mem_entry(string name, instr_t instr, logic rd, logic wr,
                             mem_sel_t msel, word_t addr, word_t wdata);
        start_entry(name, instr);
        t_rd[entry_count]    = rd;
        t_wr[entry_count]    = wr;
        t_msel[entry_count]  = msel;
        t_addr[entry_count]  = addr;
        t_wdata[entry_count] = wdata;
        entry_count++;
    endtask

    task automatic build_table();
        alu_entry("addi_x1", i_type(5, 0, 0, 1, OPC_OP_IMM), 32'h0000_0005);
        alu_entry("addi_x2", i_type(-3, 0, 0, 2, OPC_OP_IMM), 32'hFFFF_FFFD);
        alu_entry("add_x3", r_type(0, 2, 1, 0, 3), 32'h0000_0002);
        alu_entry("sub_x4", r_type('h20, 1, 3, 0, 4), 32'hFFFF_FFFD);
        alu_entry("slli_x5", i_type(4, 1, 1, 5, OPC_OP_IMM), 32'h0000_0050);
        alu_entry("srai_x6", i_type('h401, 2, 5, 6, OPC_OP_IMM), 32'hFFFF_FFFE);
        alu_entry("srli_x7", i_type(28, 2, 5, 7, OPC_OP_IMM), 32'h0000_000F);
        alu_entry("slt_x8", r_type(0, 1, 2, 2, 8), 32'h0000_0001);
        alu_entry("sltu_x9", r_type(0, 1, 2, 3, 9), 32'h0000_0000);
        alu_entry("addi_x0", i_type(7, 1, 0, 0, OPC_OP_IMM), 32'h0000_000C);
        alu_entry("add_x10_x0", r_type(0, 1, 0, 0, 10), 32'h0000_0005);
        alu_entry("lui", u_type('h12345, 11, OPC_LUI), 32'h1234_5000);
        alu_entry("auipc", u_type('h1, 12, OPC_AUIPC), 32'h0000_1130);
        ctrl_entry("beq_taken", b_type(16, 10, 1, 0), 1'b0, '0, 1'b1, 32'h0000_0144);
        ctrl_entry("bne_not", b_type(8, 10, 1, 1), 1'b0, '0, 1'b0, '0);
        ctrl_entry("blt_taken", b_type(-8, 1, 2, 4), 1'b0, '0, 1'b1, 32'h0000_0134);
        ctrl_entry("bgeu_not", b_type(12, 2, 1, 7), 1'b0, '0, 1'b0, '0);
        ctrl_entry("bgeu_taken", b_type('h20, 1, 2, 7), 1'b0, '0, 1'b1, 32'h0000_0164);
        ctrl_entry("jal", j_type('h100, 13), 1'b1, 32'h0000_014C, 1'b1, 32'h0000_0248);
        ctrl_entry("jalr", i_type(10, 1, 0, 14, OPC_JALR), 1'b1, 32'h0000_0150,
                   1'b1, 32'h0000_000E);
        mem_entry("lw", i_type(8, 1, 2, 15, OPC_LOAD), 1'b1, 1'b0, 3'b010,
                  32'h0000_000D, '0);
        // Store offset bits [4:0] sit in the rd field, here x30.
        mem_entry("sh", s_type(-2, 2, 5, 1), 1'b0, 1'b1, 3'b001,
                  32'h0000_004E, 32'hFFFF_FFFD);
        mem_entry("lhu", i_type(4, 3, 5, 16, OPC_LOAD), 1'b1, 1'b0, 3'b101,
                  32'h0000_0006, '0);
        alu_entry("add_x17", r_type(0, 16, 15, 0, 17), 32'h0000_0000);
        alu_entry("addi_x18", i_type(1, 30, 0, 18, OPC_OP_IMM), 32'h0000_0001);
    endtask

    task automatic check_word(string name, string what, word_t exp, word_t act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %h, actual %h", name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_flag(string name, string what, logic exp, logic act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %b, actual %b", name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_mem_sel(string name, string what, mem_sel_t exp, mem_sel_t act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %b, actual %b", name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic report_test(string name, int errs_before);
        if (error_count == errs_before) begin
            $display("test %s passed", name);
            pass_count++;
        end else begin
            $display("test %s failed", name);
            fail_count++;
        end
    endtask

    // Waits for the result of the instruction driven on the last falling edge.
    task automatic wait_result(output logic seen);
        int cycles;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < MAX_WAIT) begin
            @(negedge clk_i);
            cycles++;
            if (result_valid_o === 1'b1) begin
                seen = 1'b1;
            end
        end
    endtask

    task automatic compare_outputs(int i);
        if (t_chk_res[i]) begin
            check_word(t_name[i], "result_o", t_res[i], result_o);
        end
        check_flag(t_name[i], "pc_wr_en_o", t_br[i], pc_wr_en_o);
        if (t_br[i]) begin
            check_word(t_name[i], "pc_target_o", t_tgt[i], pc_target_o);
        end
        check_flag(t_name[i], "dram_rd_en_o", t_rd[i], dram_rd_en_o);
        check_flag(t_name[i], "dram_wr_en_o", t_wr[i], dram_wr_en_o);
        if (t_rd[i]) begin
            check_mem_sel(t_name[i], "dram_rd_sel_o", t_msel[i], dram_rd_sel_o);
            check_word(t_name[i], "dram_addr_o", t_addr[i], dram_addr_o);
        end
        if (t_wr[i]) begin
            check_mem_sel(t_name[i], "dram_wr_sel_o", t_msel[i], dram_wr_sel_o);
            check_word(t_name[i], "dram_addr_o", t_addr[i], dram_addr_o);
            check_word(t_name[i], "dram_wr_data_o", t_wdata[i], dram_wr_data_o);
        end
    endtask

    initial begin
        int   errs_before;
        logic seen;
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        build_table();
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        errs_before = error_count;
        check_flag("reset", "result_valid_o", 1'b0, result_valid_o);
        check_flag("reset", "pc_wr_en_o", 1'b0, pc_wr_en_o);
        check_flag("reset", "dram_rd_en_o", 1'b0, dram_rd_en_o);
        check_flag("reset", "dram_wr_en_o", 1'b0, dram_wr_en_o);
        report_test("reset", errs_before);

        // Back to back issue, so dependent reads go through the bypass.
        for (int i = 0; i < entry_count && !timed_out; i++) begin
            instr_valid_i = 1'b1;
            instr_i       = t_instr[i];
            pc_i          = t_pc[i];
            errs_before   = error_count;
            wait_result(seen);
            if (seen) begin
                compare_outputs(i);
                report_test(t_name[i], errs_before);
            end else begin
                $display("test %s failed: result_valid_o did not rise within %0d cycles",
                         t_name[i], MAX_WAIT);
                fail_count++;
                timed_out = 1'b1;
            end
        end
        instr_valid_i = 1'b0;

        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (timed_out || fail_count != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

endmodule
